// ==== rtl/host_io_pkg.sv ====
// host i/o shared types
package host_io_pkg;

	// command codes sent in the first word of a transfer
	typedef enum logic [7:0] {
		BUTTONS  = 8'h01,
		JOY0     = 8'h02,
		JOY1     = 8'h03,
		MOUSE    = 8'h04,
		KEYBOARD = 8'h05,
		OSD_KEY  = 8'h06,
		JOY2     = 8'h10,
		JOY3     = 8'h11,
		CONF_STR = 8'h14,
		RTC      = 8'h22,
		VID_INFO = 8'h23,
		BLANKING = 8'h2D
	} host_cmd_t;

	// command of each joystick slot, by index
	localparam host_cmd_t JOY_CMD [4] = '{JOY0, JOY1, JOY2, JOY3};

	// one decoded word, idx 0 is the command word
	typedef struct packed {
		logic       valid;
		host_cmd_t  cmd;
		logic [5:0] idx;
		logic [15:0] data;
	} host_word_t;

	typedef struct packed {
		logic      valid;
		host_cmd_t cmd;
	} xfer_end_t;

	// keyboard and mouse event types
	localparam logic [1:0] KM_MOUSE_X = 2'd0;
	localparam logic [1:0] KM_MOUSE_Y = 2'd1;
	localparam logic [1:0] KM_KEY     = 2'd2;
	localparam logic [1:0] KM_MENU    = 2'd3;

	typedef struct packed {
		logic [1:0] typ;
		logic [7:0] data;
	} km_event_t;

	// blanking borders, low 12 bits significant
	typedef struct packed {
		logic [15:0] hbl_l;
		logic [15:0] hbl_r;
		logic [15:0] vbl_t;
		logic [15:0] vbl_b;
	} blank_t;

	typedef struct packed {
		logic [7:0]  nres;
		logic [15:0] hact;
		logic [15:0] vact;
		logic [31:0] htime;
		logic [31:0] vtime;
	} vid_info_t;

endpackage

// ==== rtl/host_cmd_decoder.sv ====
// host port command decoder
module host_cmd_decoder
	import host_io_pkg::*;
#(
	parameter int WAIT_CYCLES = 8
) (
	input  logic        clk_100,
	input  logic        rst_n,
	input  logic        uio_ena,
	input  logic        io_strobe,
	input  logic [15:0] io_din,
	output host_word_t  word,
	output xfer_end_t   xfer_end,
	output logic        io_wait
);

	localparam int TW = $clog2(WAIT_CYCLES + 1);

	logic          uio_ena_q;
	host_cmd_t     cmd_q;
	logic [5:0]    cnt_q;
	logic [TW-1:0] wait_cnt_q;

	////////////////////////////////////////////////////////////////////////////
	// word labelling, io_wait countdown, end of transfer
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_100 or negedge rst_n) begin
		if (!rst_n) begin
			uio_ena_q  <= 1'b0;
			cmd_q      <= host_cmd_t'(8'h00);
			cnt_q      <= '0;
			wait_cnt_q <= '0;
			io_wait    <= 1'b0;
			word       <= '0;
			xfer_end   <= '0;
		end else begin
			uio_ena_q      <= uio_ena;
			word.valid     <= 1'b0;
			xfer_end.valid <= 1'b0;

			if (!uio_ena) begin
				// idle between transfers
				cnt_q      <= '0;
				wait_cnt_q <= '0;
				io_wait    <= 1'b0;
				cmd_q      <= host_cmd_t'(8'h00);
				if (uio_ena_q) begin
					xfer_end.valid <= 1'b1;
					xfer_end.cmd   <= cmd_q;
				end
			end else if (io_strobe) begin
				word.valid <= 1'b1;
				word.idx   <= cnt_q;
				word.data  <= io_din;
				if (cnt_q == 6'd0) begin
					// first word carries the command
					word.cmd <= host_cmd_t'(io_din[7:0]);
					cmd_q    <= host_cmd_t'(io_din[7:0]);
				end else begin
					word.cmd <= cmd_q;
				end
				// index saturates at 63
				if (cnt_q != 6'h3f)
					cnt_q <= cnt_q + 6'd1;
				io_wait    <= 1'b1;
				wait_cnt_q <= TW'(WAIT_CYCLES - 1);
			end else if (wait_cnt_q != '0) begin
				wait_cnt_q <= wait_cnt_q - 1'b1;
			end else begin
				io_wait <= 1'b0;
			end
		end
	end

endmodule

// ==== rtl/io_reg_slot.sv ====
// command payload register
module io_reg_slot
	import host_io_pkg::*;
#(
	parameter type       T   = logic [15:0],
	parameter host_cmd_t CMD = BUTTONS
) (
	input  logic       clk_100,
	input  logic       rst_n,
	input  host_word_t word,
	input  xfer_end_t  xfer_end,
	output T           value,
	output logic       update
);

	localparam int W  = $bits(T);
	localparam int NW = W / 16;

	logic [W-1:0] shadow_q;
	logic         word_hit;
	logic         commit;

	// payload words 1..NW of our own command
	assign word_hit = word.valid && (word.cmd == CMD) && (word.idx != 6'd0) &&
		(int'(word.idx) <= NW);
	assign commit = xfer_end.valid && (xfer_end.cmd == CMD);

	always_ff @(posedge clk_100 or negedge rst_n) begin
		if (!rst_n) begin
			shadow_q <= '0;
			value    <= '0;
			update   <= 1'b0;
		end else begin
			update <= 1'b0;

			// word n lands in slice n-1, lowest first
			if (word_hit)
				shadow_q[16*(int'(word.idx) - 1) +: 16] <= word.data;

			// output changes only once the transfer is over
			if (commit) begin
				value  <= T'(shadow_q);
				update <= 1'b1;
			end
		end
	end

endmodule

// ==== rtl/kbd_mouse_events.sv ====
// keyboard, mouse and menu events
module kbd_mouse_events
	import host_io_pkg::*;
(
	input  logic       clk_100,
	input  logic       rst_n,
	input  host_word_t word,
	output km_event_t  km_event,
	output logic       km_strobe,
	output logic       km_level,
	output logic [2:0] mouse_buttons
);

	logic      ev_hit;
	km_event_t ev_next;

	// pick event type from command and word index
	always_comb begin
		ev_hit       = 1'b0;
		ev_next.typ  = KM_MOUSE_X;
		ev_next.data = word.data[7:0];
		if (word.valid) begin
			case (word.cmd)
				MOUSE: begin
					if (word.idx == 6'd1) begin
						ev_hit      = 1'b1;
						ev_next.typ = KM_MOUSE_X;
					end
					if (word.idx == 6'd2) begin
						ev_hit      = 1'b1;
						ev_next.typ = KM_MOUSE_Y;
					end
				end
				KEYBOARD: begin
					ev_hit      = (word.idx == 6'd1);
					ev_next.typ = KM_KEY;
				end
				OSD_KEY: begin
					ev_hit      = (word.idx == 6'd1);
					ev_next.typ = KM_MENU;
				end
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk_100 or negedge rst_n) begin
		if (!rst_n) begin
			km_event      <= '0;
			km_strobe     <= 1'b0;
			km_level      <= 1'b0;
			mouse_buttons <= '0;
		end else begin
			km_strobe <= ev_hit;
			if (ev_hit) begin
				km_event <= ev_next;
				km_level <= ~km_level;
			end
			// third mouse word holds the button state
			if (word.valid && word.cmd == MOUSE && word.idx == 6'd3)
				mouse_buttons <= word.data[2:0];
		end
	end

endmodule

// ==== rtl/video_timing_meter.sv ====
// video timing meter
module video_timing_meter
	import host_io_pkg::*;
(
	input  logic      clk_100,
	input  logic      rst_n,
	input  logic      ce_pix,
	input  logic      de,
	input  logic      hs,
	input  logic      vs,
	input  logic      new_vmode,
	output vid_info_t vid_info
);

	logic        vs_pix_q;
	logic        de_pix_q;
	logic        calc_h_q;
	logic        vmode_q;
	logic [15:0] hcnt_q;
	logic [15:0] vcnt_q;
	logic [3:0]  settle_q;
	logic        size_changed;

	logic        hs_clk_q;
	logic        vs_clk_q;
	logic [31:0] hcyc_q;
	logic [31:0] vcyc_q;
	logic [31:0] htime_q;
	logic [31:0] vtime_q;

	assign size_changed = (hcnt_q != vid_info.hact) || (vcnt_q != vid_info.vact) ||
		(vmode_q != new_vmode);

	////////////////////////////////////////////////////////////////////////////
	// active size, counted on pixel enable
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_100 or negedge rst_n) begin
		if (!rst_n) begin
			vs_pix_q <= 1'b0;
			de_pix_q <= 1'b0;
			calc_h_q <= 1'b0;
			vmode_q  <= 1'b0;
			hcnt_q   <= '0;
			vcnt_q   <= '0;
			settle_q <= '0;
			vid_info <= '0;
		end else if (ce_pix) begin
			vs_pix_q <= vs;
			de_pix_q <= de;

			// lines counted on de rise, pixels only on the first active line
			if (!vs && !de_pix_q && de)
				vcnt_q <= vcnt_q + 16'd1;
			if (calc_h_q && de)
				hcnt_q <= hcnt_q + 16'd1;
			if (de_pix_q && !de)
				calc_h_q <= 1'b0;

			if (vs_pix_q && !vs) begin
				if (hcnt_q != 16'd0 && vcnt_q != 16'd0) begin
					vmode_q <= new_vmode;
					// settle counter restarts on any change and wraps after 15
					if (settle_q != 4'd0)
						settle_q <= settle_q + 4'd1;
					if (size_changed)
						settle_q <= 4'd1;
					if (&settle_q)
						vid_info.nres <= vid_info.nres + 8'd1;
					vid_info.hact  <= hcnt_q;
					vid_info.vact  <= vcnt_q;
					vid_info.htime <= htime_q;
					vid_info.vtime <= vtime_q;
				end
				hcnt_q   <= '0;
				vcnt_q   <= '0;
				calc_h_q <= 1'b1;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// line and frame period in clk_100 cycles
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_100 or negedge rst_n) begin
		if (!rst_n) begin
			hs_clk_q <= 1'b0;
			vs_clk_q <= 1'b0;
			hcyc_q   <= '0;
			vcyc_q   <= '0;
			htime_q  <= '0;
			vtime_q  <= '0;
		end else begin
			hs_clk_q <= hs;
			vs_clk_q <= vs;
			hcyc_q   <= hcyc_q + 32'd1;
			vcyc_q   <= vcyc_q + 32'd1;
			// restart at 1 so the latched value is the full period
			if (hs && !hs_clk_q) begin
				htime_q <= hcyc_q;
				hcyc_q  <= 32'd1;
			end
			if (vs && !vs_clk_q) begin
				vtime_q <= vcyc_q;
				vcyc_q  <= 32'd1;
			end
		end
	end

endmodule

// ==== rtl/host_readback.sv ====
// host readback data
module host_readback
	import host_io_pkg::*;
#(
	parameter int                  STRLEN   = 5,
	parameter logic [8*STRLEN-1:0] CONF_STR = "CORE;"
) (
	input  logic        clk_100,
	input  logic        rst_n,
	input  host_word_t  word,
	input  vid_info_t   vid_info,
	output logic [15:0] io_dout
);

	logic [15:0] reply;

	// reply for the word just decoded
	always_comb begin
		reply = '0;
		if (word.cmd == host_io_pkg::CONF_STR) begin
			// leading character sits in the top byte of the string
			if (word.idx != 6'd0 && int'(word.idx) <= STRLEN)
				reply[7:0] = CONF_STR[8*(STRLEN - int'(word.idx)) +: 8];
		end else if (word.cmd == VID_INFO) begin
			case (word.idx)
				6'd1:    reply = {8'h00, vid_info.nres};
				6'd2:    reply = vid_info.hact;
				6'd3:    reply = vid_info.vact;
				6'd4:    reply = vid_info.htime[15:0];
				6'd5:    reply = vid_info.htime[31:16];
				6'd6:    reply = vid_info.vtime[15:0];
				6'd7:    reply = vid_info.vtime[31:16];
				default: reply = '0;
			endcase
		end
	end

	// held until the next word arrives
	always_ff @(posedge clk_100 or negedge rst_n) begin
		if (!rst_n)
			io_dout <= '0;
		else if (word.valid)
			io_dout <= reply;
	end

endmodule

// ==== rtl/host_io_top.sv ====
// host i/o block top level
module host_io_top
	import host_io_pkg::*;
#(
	parameter int                  NUM_JOY     = 4,
	parameter int                  WAIT_CYCLES = 8,
	parameter int                  STRLEN      = 5,
	parameter logic [8*STRLEN-1:0] CONF_STR    = "CORE;"
) (
	input  logic                    clk_100,
	input  logic                    rst_n,
	input  logic                    uio_ena,
	input  logic                    io_strobe,
	input  logic [15:0]             io_din,
	output logic [15:0]             io_dout,
	output logic                    io_wait,
	input  logic                    ce_pix,
	input  logic                    de,
	input  logic                    hs,
	input  logic                    vs,
	input  logic                    new_vmode,
	output logic [NUM_JOY-1:0][15:0] joy,
	output logic [1:0]              buttons,
	output km_event_t               km_event,
	output logic                    km_strobe,
	output logic                    km_level,
	output logic [2:0]              mouse_buttons,
	output blank_t                  blank,
	output logic                    sset,
	output logic [63:0]             rtc,
	output logic                    rtc_set
);

	host_word_t  word;
	xfer_end_t   xfer_end;
	vid_info_t   vid_info;
	logic [15:0] buttons_word;

	host_cmd_decoder #(.WAIT_CYCLES(WAIT_CYCLES)) decoder_inst (
		.clk_100(clk_100), .rst_n(rst_n), .uio_ena(uio_ena), .io_strobe(io_strobe),
		.io_din(io_din), .word(word), .xfer_end(xfer_end), .io_wait(io_wait)
	);

	////////////////////////////////////////////////////////////////////////////
	// register slots
	////////////////////////////////////////////////////////////////////////////

	for (genvar g = 0; g < NUM_JOY; g++) begin : g_joy
		io_reg_slot #(.T(logic [15:0]), .CMD(JOY_CMD[g])) joy_slot_inst (
			.clk_100(clk_100), .rst_n(rst_n), .word(word), .xfer_end(xfer_end),
			.value(joy[g]), .update()
		);
	end

	io_reg_slot #(.T(logic [15:0]), .CMD(BUTTONS)) buttons_slot_inst (
		.clk_100(clk_100), .rst_n(rst_n), .word(word), .xfer_end(xfer_end),
		.value(buttons_word), .update()
	);

	// only the two low bits are wired to the core
	assign buttons = buttons_word[1:0];

	io_reg_slot #(.T(blank_t), .CMD(BLANKING)) blank_slot_inst (
		.clk_100(clk_100), .rst_n(rst_n), .word(word), .xfer_end(xfer_end),
		.value(blank), .update(sset)
	);

	io_reg_slot #(.T(logic [63:0]), .CMD(RTC)) rtc_slot_inst (
		.clk_100(clk_100), .rst_n(rst_n), .word(word), .xfer_end(xfer_end),
		.value(rtc), .update(rtc_set)
	);

	////////////////////////////////////////////////////////////////////////////
	// events, video meter and readback
	////////////////////////////////////////////////////////////////////////////

	kbd_mouse_events km_inst (
		.clk_100(clk_100), .rst_n(rst_n), .word(word), .km_event(km_event),
		.km_strobe(km_strobe), .km_level(km_level), .mouse_buttons(mouse_buttons)
	);

	video_timing_meter meter_inst (
		.clk_100(clk_100), .rst_n(rst_n), .ce_pix(ce_pix), .de(de), .hs(hs), .vs(vs),
		.new_vmode(new_vmode), .vid_info(vid_info)
	);

	host_readback #(.STRLEN(STRLEN), .CONF_STR(CONF_STR)) readback_inst (
		.clk_100(clk_100), .rst_n(rst_n), .word(word), .vid_info(vid_info),
		.io_dout(io_dout)
	);

endmodule

// ==== testbench/host_io_chk.sv ====
// host i/o port assertions
module host_io_chk #(
	parameter int NUM_JOY     = 4,
	parameter int WAIT_CYCLES = 8
) (
	input logic                     clk_100,
	input logic                     rst_n,
	input logic                     uio_ena,
	input logic                     io_strobe,
	input logic                     io_wait,
	input logic                     km_strobe,
	input logic                     km_level,
	input logic                     sset,
	input logic                     rtc_set,
	input logic [NUM_JOY-1:0][15:0] joy,
	input logic [1:0]               buttons,
	input logic [63:0]              blank,
	input logic [63:0]              rtc
);

	int fail_cnt = 0;
	int quiet;

	// cycles since the latest strobe of the current transfer
	always_ff @(posedge clk_100 or negedge rst_n) begin
		if (!rst_n)
			quiet <= 0;
		else if (!uio_ena || io_strobe)
			quiet <= 0;
		else if (quiet < 255)
			quiet <= quiet + 1;
	end

	////////////////////////////////////////////////////////////////////////////
	// host port handshake
	////////////////////////////////////////////////////////////////////////////

	a_reset_low: assert property (@(posedge clk_100)
		!rst_n |-> !(io_wait || km_strobe || km_level || sset || rtc_set))
		else begin
			fail_cnt++;
			$error("control output high while reset is held");
		end

	a_wait_rise: assert property (@(posedge clk_100) disable iff (!rst_n)
		uio_ena && io_strobe |=> io_wait)
		else begin
			fail_cnt++;
			$error("io_wait not high one cycle after a strobe");
		end

	a_wait_cause: assert property (@(posedge clk_100) disable iff (!rst_n)
		$rose(io_wait) |-> $past(uio_ena && io_strobe))
		else begin
			fail_cnt++;
			$error("io_wait rose without a strobe");
		end

	a_wait_quiet: assert property (@(posedge clk_100) disable iff (!rst_n)
		uio_ena && quiet >= WAIT_CYCLES |-> !io_wait)
		else begin
			fail_cnt++;
			$error("io_wait still high after the quiet period");
		end

	a_wait_end: assert property (@(posedge clk_100) disable iff (!rst_n)
		!uio_ena |=> !io_wait)
		else begin
			fail_cnt++;
			$error("io_wait still high after the transfer ended");
		end

	////////////////////////////////////////////////////////////////////////////
	// events and register commits
	////////////////////////////////////////////////////////////////////////////

	a_km_delay: assert property (@(posedge clk_100) disable iff (!rst_n)
		km_strobe |-> $past(uio_ena && io_strobe, 2) ##1 !km_strobe)
		else begin
			fail_cnt++;
			$error("km_strobe not a single pulse two cycles after a strobe");
		end

	a_km_level: assert property (@(posedge clk_100) disable iff (!rst_n)
		$changed(km_level) == km_strobe)
		else begin
			fail_cnt++;
			$error("km_level toggle does not match km_strobe");
		end

	a_set_pulse: assert property (@(posedge clk_100) disable iff (!rst_n)
		sset || rtc_set |-> $past(uio_ena, 3) && !$past(uio_ena, 2) ##1 !(sset || rtc_set))
		else begin
			fail_cnt++;
			$error("sset or rtc_set not a single pulse after transfer end");
		end

	// outputs move only in the commit cycle after a transfer
	a_commit: assert property (@(posedge clk_100) disable iff (!rst_n)
		$changed({joy, buttons, blank, rtc}) |-> $past(uio_ena, 3) && !$past(uio_ena, 2))
		else begin
			fail_cnt++;
			$error("register output changed outside the commit cycle");
		end

endmodule

// ==== testbench/host_io_tb.sv ====
// host i/o testbench
module host_io_tb
	import host_io_pkg::*;
();

	localparam int    NUM_JOY      = 4;
	localparam int    WAIT_CYCLES  = 8;
	localparam string CONF_TEXT    = "CORE;";
	localparam int    LINE_SLOTS   = 32;
	localparam int    FRAME_LINES  = 10;
	localparam int    ACT_PX       = 20;
	localparam int    ACT_LN       = 6;
	localparam int    FRAME_CYCLES = 2 * LINE_SLOTS * FRAME_LINES;
	localparam int    N_XFERS      = 13;
	localparam int    XFER_CYCLES  = 8 * (WAIT_CYCLES + 4);
	localparam int    RUN_FRAMES   = 20 + 17 + 3;
	localparam int    WATCHDOG     = N_XFERS * XFER_CYCLES + RUN_FRAMES * FRAME_CYCLES;

	logic clk_100 = 1'b0;
	logic rst_n, uio_ena, io_strobe, new_vmode;
	logic [15:0] io_din, io_dout;
	logic io_wait, km_strobe, km_level, sset, rtc_set;
	logic [NUM_JOY-1:0][15:0] joy;
	logic [1:0] buttons;
	logic [2:0] mouse_buttons;
	logic [63:0] rtc;
	km_event_t km_event;
	blank_t blank;

	// raster state runs free from time zero
	logic ce_pix = 1'b0;
	logic de = 1'b0;
	logic hs = 1'b0;
	logic vs = 1'b0;
	int px = 0;
	int ln = 0;
	int frame_cnt = 0;

	int seed = 32'h6cfebfb6;
	int errors = 0;
	int sset_cnt = 0;
	int rtc_set_cnt = 0;
	logic [15:0] xq[$];
	logic [15:0] dout_q[$];
	logic        kms_q[$];
	km_event_t   kme_q[$];

	host_io_top #(.NUM_JOY(NUM_JOY), .WAIT_CYCLES(WAIT_CYCLES), .STRLEN(5),
		.CONF_STR("CORE;")) host_io_top_inst (
		.clk_100(clk_100), .rst_n(rst_n), .uio_ena(uio_ena), .io_strobe(io_strobe),
		.io_din(io_din), .io_dout(io_dout), .io_wait(io_wait), .ce_pix(ce_pix), .de(de),
		.hs(hs), .vs(vs), .new_vmode(new_vmode), .joy(joy), .buttons(buttons),
		.km_event(km_event), .km_strobe(km_strobe), .km_level(km_level),
		.mouse_buttons(mouse_buttons), .blank(blank), .sset(sset), .rtc(rtc),
		.rtc_set(rtc_set)
	);

	bind host_io_top host_io_chk #(.NUM_JOY(NUM_JOY), .WAIT_CYCLES(WAIT_CYCLES)) chk_inst (
		.clk_100(clk_100), .rst_n(rst_n), .uio_ena(uio_ena), .io_strobe(io_strobe),
		.io_wait(io_wait), .km_strobe(km_strobe), .km_level(km_level), .sset(sset),
		.rtc_set(rtc_set), .joy(joy), .buttons(buttons), .blank(blank), .rtc(rtc)
	);

	always #5 clk_100 = ~clk_100;

	// pixel slot every second cycle, 20 of 32 slots and 6 of 10 lines active
	always @(negedge clk_100) begin
		if (ce_pix) begin
			if (px == LINE_SLOTS - 1) begin
				px = 0;
				if (ln == FRAME_LINES - 1) begin
					ln = 0;
					frame_cnt++;
				end else begin
					ln++;
				end
			end else begin
				px++;
			end
		end
		ce_pix = !ce_pix;
		de = (px >= 4) && (px < 4 + ACT_PX) && (ln >= 1) && (ln < 1 + ACT_LN);
		hs = (px >= 26) && (px < 30);
		vs = (ln >= 8);
	end

	always @(negedge clk_100) begin
		if (sset)
			sset_cnt++;
		if (rtc_set)
			rtc_set_cnt++;
	end

	initial begin
		repeat (WATCHDOG) @(posedge clk_100);
		$display("watchdog expired before the tests finished");
		$display("=== FAIL ===");
		$finish;
	end

	////////////////////////////////////////////////////////////////////////////
	// helpers
	////////////////////////////////////////////////////////////////////////////

	function automatic logic [15:0] cmd_word(input host_cmd_t c);
		return {8'h00, c};
	endfunction

	task automatic check_value(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp);
		end
	endtask

	// sends the words in xq, recording reply and event state per word
	task automatic run_xfer(input bit early_end = 1'b0);
		dout_q.delete();
		kms_q.delete();
		kme_q.delete();
		uio_ena = 1'b1;
		@(negedge clk_100);
		foreach (xq[i]) begin
			io_din    = xq[i];
			io_strobe = 1'b1;
			@(negedge clk_100);
			io_strobe = 1'b0;
			@(negedge clk_100);
			dout_q.push_back(io_dout);
			kms_q.push_back(km_strobe);
			kme_q.push_back(km_event);
			// an early end drops uio_ena while io_wait is still high
			if (!early_end || i != xq.size() - 1) begin
				while (io_wait)
					@(negedge clk_100);
			end
		end
		uio_ena = 1'b0;
		xq.delete();
		repeat (3) @(negedge clk_100);
	endtask

	task automatic check_event(input int i, input logic [1:0] typ, input logic [7:0] data);
		check_value($sformatf("km_strobe word %0d", i), kms_q[i], 1);
		check_value($sformatf("km_event word %0d", i), kme_q[i], {typ, data});
	endtask

	task automatic check_vid_info(input logic [7:0] nres_exp);
		xq.push_back(cmd_word(VID_INFO));
		repeat (7) xq.push_back(16'h0000);
		run_xfer();
		check_value("vid_info nres", dout_q[1], nres_exp);
		check_value("vid_info hact", dout_q[2], ACT_PX);
		check_value("vid_info vact", dout_q[3], ACT_LN);
		check_value("vid_info htime", {dout_q[5], dout_q[4]}, 2 * LINE_SLOTS);
		check_value("vid_info vtime", {dout_q[7], dout_q[6]}, FRAME_CYCLES);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// test sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		logic [15:0] exp_joy [NUM_JOY];
		logic [15:0] w [4];
		logic [15:0] exp;
		int f0;
		int asrt;
		rst_n     = 1'b0;
		uio_ena   = 1'b0;
		io_strobe = 1'b0;
		io_din    = '0;
		new_vmode = 1'b0;
		repeat (5) @(negedge clk_100);
		rst_n = 1'b1;
		@(negedge clk_100);
		check_value("control outputs", {io_wait, km_strobe, km_level, sset, rtc_set}, 0);

		// joysticks one at a time, other slots must hold
		for (int j = 0; j < NUM_JOY; j++)
			exp_joy[j] = '0;
		for (int j = 0; j < NUM_JOY; j++) begin
			exp_joy[j] = 16'($random(seed));
			xq.push_back(cmd_word(JOY_CMD[j]));
			xq.push_back(exp_joy[j]);
			run_xfer();
			for (int k = 0; k < NUM_JOY; k++)
				check_value($sformatf("joy[%0d]", k), joy[k], exp_joy[k]);
		end
		w[0] = 16'($random(seed));
		xq.push_back(cmd_word(BUTTONS));
		xq.push_back(w[0]);
		run_xfer();
		check_value("buttons", buttons, w[0][1:0]);

		// four-word registers
		xq.push_back(cmd_word(BLANKING));
		for (int i = 0; i < 4; i++) begin
			w[i] = 16'($random(seed));
			xq.push_back(w[i]);
		end
		f0 = sset_cnt;
		run_xfer();
		check_value("blank", blank, {w[3], w[2], w[1], w[0]});
		check_value("sset pulses", sset_cnt - f0, 1);
		xq.push_back(cmd_word(RTC));
		for (int i = 0; i < 4; i++) begin
			w[i] = 16'($random(seed));
			xq.push_back(w[i]);
		end
		f0 = rtc_set_cnt;
		run_xfer();
		check_value("rtc", rtc, {w[3], w[2], w[1], w[0]});
		check_value("rtc_set pulses", rtc_set_cnt - f0, 1);

		// mouse, keyboard and menu events
		xq.push_back(cmd_word(MOUSE));
		for (int i = 0; i < 3; i++) begin
			w[i] = 16'($random(seed));
			xq.push_back(w[i]);
		end
		run_xfer();
		check_event(1, 2'd0, w[0][7:0]);
		check_event(2, 2'd1, w[1][7:0]);
		check_value("km_strobe word 3", kms_q[3], 0);
		check_value("mouse_buttons", mouse_buttons, w[2][2:0]);
		w[0] = 16'($random(seed));
		xq.push_back(cmd_word(KEYBOARD));
		xq.push_back(w[0]);
		// ends the transfer while io_wait is still high
		run_xfer(1'b1);
		check_event(1, 2'd2, w[0][7:0]);
		w[0] = 16'($random(seed));
		xq.push_back(cmd_word(OSD_KEY));
		xq.push_back(w[0]);
		run_xfer();
		check_event(1, 2'd3, w[0][7:0]);

		// config string, zero past its end
		xq.push_back(cmd_word(CONF_STR));
		repeat (7) xq.push_back(16'h0000);
		run_xfer();
		for (int i = 1; i <= 7; i++) begin
			exp = (i <= CONF_TEXT.len()) ? {8'h00, CONF_TEXT[i-1]} : 16'h0000;
			check_value($sformatf("io_dout conf word %0d", i), dout_q[i], exp);
		end

		// video timing, then a mode change and the settle period
		while (frame_cnt < 20)
			@(negedge clk_100);
		check_vid_info(8'd1);
		new_vmode = 1'b1;
		f0 = frame_cnt;
		while (frame_cnt < f0 + 17)
			@(negedge clk_100);
		check_vid_info(8'd2);

		asrt = host_io_top_inst.chk_inst.fail_cnt;
		$display("done: %0d check errors, %0d assertion failures", errors, asrt);
		if (errors + asrt == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

// ==== sources.f ====
rtl/host_io_pkg.sv
rtl/host_cmd_decoder.sv
rtl/io_reg_slot.sv
rtl/kbd_mouse_events.sv
rtl/video_timing_meter.sv
rtl/host_readback.sv
rtl/host_io_top.sv
testbench/host_io_chk.sv
testbench/host_io_tb.sv

// ==== Makefile ====
VERILATOR  = verilator
VFLAGS     = --timing --assert -Wno-fatal
TOP        = host_io_tb
FILELIST   = sources.f
OBJ_DIR    = obj_dir
LOG        = sim.log
FAIL_MSG   = === FAIL ===
PASS_MSG   = === PASS ===

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qF -- "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -qF -- "$(PASS_MSG)" $(LOG); then echo "simulation ended without a pass"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
